//--- psx_loader_params.svh
// Download slot codes, RAM region bases and bus widths for the loader path
`ifndef PSX_LOADER_PARAMS_SVH
`define PSX_LOADER_PARAMS_SVH

// ==================================================
// Host download slot codes
// ==================================================

`define PSX_IDX_BIOS 8'd0
`define PSX_IDX_EXE 8'd1
// CD images arrive on several slots, only the low 6 bits matter
`define PSX_IDX_CD 8'd2
`define PSX_IDX_CD_MASK 8'h3F
// Protection key (SBI) file
`define PSX_IDX_SBI 8'd250

// ==================================================
// RAM regions
// ==================================================

`define PSX_BIOS_BASE 27'd2097152
`define PSX_EXE_BASE 27'd4194304

// ==================================================
// Widths
// ==================================================

`define PSX_ADDR_W 27
`define PSX_HWORD_W 16
`define PSX_WORD_W 32
`define PSX_BE_W 4

// Byte count of a mounted CD image
`define PSX_CDSIZE_W 30

`endif

//--- psx_loader_pkg.sv
// Download kind enum and the packed structs shared by the loader path
`default_nettype none

`include "psx_loader_params.svh"

package psx_loader_pkg;

	// Kind of download currently in progress
	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CD,
		DL_SBI
	} dl_kind_t;

	// Host beat after the classify register, 47 bits
	typedef struct packed {
		dl_kind_t kind;
		logic wr;
		logic [`PSX_ADDR_W-1:0] addr;
		logic [`PSX_HWORD_W-1:0] data;
	} dl_beat_t;

	// One request on the RAM write port, 64 bits
	typedef struct packed {
		logic req;
		logic [`PSX_ADDR_W-1:0] addr;
		logic [`PSX_WORD_W-1:0] data;
		logic [`PSX_BE_W-1:0] be;
	} ram_wr_t;

	// Image mount strobes from the host, 67 bits
	typedef struct packed {
		logic cd_mount;
		logic card1_mount;
		logic card2_mount;
		logic [63:0] img_size;
	} media_evt_t;

endpackage

`default_nettype wire

//--- dl_classify.sv
// Download classify stage with slot decode and host beat register
`default_nettype none

`include "psx_loader_params.svh"

module dl_classify (
	input wire logic clk_1x,
	input wire logic rst,
	input wire logic ioctl_download,
	input wire logic [7:0] ioctl_index,
	input wire logic ioctl_wr,
	input wire logic [`PSX_ADDR_W-1:0] ioctl_addr,
	input wire logic [`PSX_HWORD_W-1:0] ioctl_dout,
	output psx_loader_pkg::dl_beat_t beat
);

	import psx_loader_pkg::*;

	dl_kind_t kind_d;

	// Slot index to download kind, only while the host is downloading
	always_comb begin
		kind_d = DL_NONE;
		if (ioctl_download) begin
			if (ioctl_index == `PSX_IDX_BIOS) begin
				kind_d = DL_BIOS;
			end else if (ioctl_index == `PSX_IDX_EXE) begin
				kind_d = DL_EXE;
			end else if ((ioctl_index & `PSX_IDX_CD_MASK) == `PSX_IDX_CD) begin
				kind_d = DL_CD;
			end else if (ioctl_index == `PSX_IDX_SBI) begin
				kind_d = DL_SBI;
			end
		end
	end

	// Kind and strobe
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			beat.kind <= DL_NONE;
			beat.wr <= 1'b0;
		end else begin
			beat.kind <= kind_d;
			beat.wr <= ioctl_wr;
		end
	end

	// Address and data ride along with the kind
	always_ff @(posedge clk_1x) begin
		beat.addr <= ioctl_addr;
		beat.data <= ioctl_dout;
	end

endmodule

`default_nettype wire

//--- word_packer.sv
// Word packer stage with 16-to-32 bit assembly, region offset and host wait
`default_nettype none

`include "psx_loader_params.svh"

module word_packer (
	input wire logic clk_1x,
	input wire logic rst,
	input wire psx_loader_pkg::dl_beat_t beat,
	input wire logic loader_ack,
	output psx_loader_pkg::ram_wr_t loader_wr,
	output logic loader_busy,
	output logic ioctl_wait
);

	import psx_loader_pkg::*;

	logic ram_kind;
	logic hi_beat;
	logic [`PSX_ADDR_W-1:0] region_base;
	logic req_q;
	logic wait_q;
	logic [`PSX_ADDR_W-1:0] addr_q;
	logic [`PSX_WORD_W-1:0] data_q;

	// BIOS, EXE and CD all land in RAM
	assign ram_kind = (beat.kind == DL_BIOS) || (beat.kind == DL_EXE) ||
		(beat.kind == DL_CD);

	// Address bit 1 selects the upper half of the word
	assign hi_beat = ram_kind && beat.wr && beat.addr[1];

	always_comb begin
		case (beat.kind)
			DL_BIOS: region_base = `PSX_BIOS_BASE;
			DL_EXE: region_base = `PSX_EXE_BASE;
			// CD image sits at the bottom of RAM
			default: region_base = '0;
		endcase
	end

	// ==================================================
	// Request pulse and host wait
	// ==================================================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			req_q <= 1'b0;
			wait_q <= 1'b0;
		end else begin
			req_q <= hi_beat;
			if (!ram_kind) begin
				// Nothing pending outside a RAM download
				wait_q <= 1'b0;
			end else if (hi_beat) begin
				wait_q <= 1'b1;
			end else if (loader_ack) begin
				wait_q <= 1'b0;
			end
		end
	end

	// ==================================================
	// Word assembly
	// ==================================================

	always_ff @(posedge clk_1x) begin
		if (ram_kind && beat.wr) begin
			if (!beat.addr[1]) begin
				// Low half fixes the target address
				data_q[`PSX_HWORD_W-1:0] <= beat.data;
				addr_q <= beat.addr + region_base;
			end else begin
				data_q[`PSX_WORD_W-1:`PSX_HWORD_W] <= beat.data;
			end
		end
	end

	// Loader writes always cover the full word
	assign loader_wr = '{
		req: req_q,
		addr: addr_q,
		data: data_q,
		be: {`PSX_BE_W{1'b1}}
	};

	assign loader_busy = ram_kind;
	assign ioctl_wait = wait_q;

endmodule

`default_nettype wire

//--- ram_write_mux.sv
// RAM write port arbiter between the download loader and the core
`default_nettype none

module ram_write_mux (
	input wire logic loader_busy,
	input wire psx_loader_pkg::ram_wr_t loader_wr,
	input wire psx_loader_pkg::ram_wr_t core_wr,
	input wire logic mem_ack,
	output psx_loader_pkg::ram_wr_t mem_wr,
	output logic loader_ack,
	output logic core_ack
);

	// ==================================================
	// Port ownership
	// ==================================================

	// Loader owns the port for the whole download
	// Core requests are not forwarded meanwhile
	always_comb begin
		if (loader_busy) begin
			mem_wr = loader_wr;
		end else begin
			mem_wr = core_wr;
		end
	end

	// ==================================================
	// Acknowledge steering
	// ==================================================

	// Ack goes only to the current owner
	always_comb begin
		loader_ack = 1'b0;
		core_ack = 1'b0;
		if (loader_busy) begin
			loader_ack = mem_ack;
		end else begin
			core_ack = mem_ack;
		end
	end

endmodule

`default_nettype wire

//--- media_tracker.sv
// CD size and presence, memory cards, load/save pulses and protection key tracking
`default_nettype none

`include "psx_loader_params.svh"

module media_tracker (
	input wire logic clk_1x,
	input wire logic rst,
	input wire psx_loader_pkg::dl_beat_t beat,
	input wire psx_loader_pkg::media_evt_t media,
	input wire logic bk_load,
	input wire logic bk_save,
	input wire logic bk_autosave,
	input wire logic osd_status,
	output logic load_exe,
	output logic has_cd,
	output logic cd_hps_on,
	output logic [`PSX_CDSIZE_W-1:0] cd_size,
	output logic card1_mounted,
	output logic card2_mounted,
	output logic memcard1_load,
	output logic memcard2_load,
	output logic memcard_save,
	output logic [`PSX_HWORD_W-1:0] libcrypt_key
);

	import psx_loader_pkg::*;

	logic is_exe;
	logic is_cd;
	logic exe_q;
	logic cd_q;
	logic cd_done;
	logic img_present;
	// {load, save, autosave} requests
	logic [2:0] req_q;
	logic [2:0] req_prev;
	logic [2:0] req_rise;

	assign is_exe = (beat.kind == DL_EXE);
	assign is_cd = (beat.kind == DL_CD);
	assign cd_done = cd_q && !is_cd;
	assign img_present = |media.img_size;
	assign req_rise = req_q & ~req_prev;

	// ==================================================
	// Control flags and pulses
	// ==================================================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			exe_q <= 1'b0;
			cd_q <= 1'b0;
			load_exe <= 1'b0;
			has_cd <= 1'b0;
			cd_hps_on <= 1'b0;
			card1_mounted <= 1'b0;
			card2_mounted <= 1'b0;
			memcard1_load <= 1'b0;
			memcard2_load <= 1'b0;
			memcard_save <= 1'b0;
			req_q <= '0;
			req_prev <= '0;
		end else begin
			exe_q <= is_exe;
			cd_q <= is_cd;
			load_exe <= exe_q && !is_exe;

			// Downloaded image is served from RAM, not from the HPS
			if (cd_done) begin
				has_cd <= 1'b1;
				cd_hps_on <= 1'b0;
			end
			if (media.cd_mount) begin
				has_cd <= img_present;
				if (img_present) begin
					cd_hps_on <= 1'b1;
				end
			end

			if (media.card1_mount) begin
				card1_mounted <= img_present;
			end
			if (media.card2_mount) begin
				card2_mounted <= img_present;
			end

			req_q <= {bk_load, bk_save, osd_status & bk_autosave};
			req_prev <= req_q;

			memcard1_load <= (media.card1_mount && img_present) || req_rise[2];
			memcard2_load <= (media.card2_mount && img_present) || req_rise[2];
			memcard_save <= req_rise[1] || req_rise[0];
		end
	end

	// ==================================================
	// CD size and protection key
	// ==================================================

	always_ff @(posedge clk_1x) begin
		if (cd_done) begin
			cd_size <= {{(`PSX_CDSIZE_W-`PSX_ADDR_W){1'b0}}, beat.addr};
		end
		// Mount wins over a download ending in the same cycle
		if (media.cd_mount && img_present) begin
			cd_size <= media.img_size[`PSX_CDSIZE_W-1:0];
		end
		if (beat.kind == DL_SBI && beat.wr) begin
			libcrypt_key <= beat.data;
		end
	end

endmodule

`default_nettype wire

//--- psx_loader_top.sv
// Loader top level with classify, pack, write-port mux and media tracker instances
`default_nettype none

`include "psx_loader_params.svh"

module psx_loader_top (
	input wire logic clk_1x,
	input wire logic rst,
	// Host download interface
	input wire logic ioctl_download,
	input wire logic [7:0] ioctl_index,
	input wire logic ioctl_wr,
	input wire logic [`PSX_ADDR_W-1:0] ioctl_addr,
	input wire logic [`PSX_HWORD_W-1:0] ioctl_dout,
	output logic ioctl_wait,
	// Core and memory write ports
	input wire psx_loader_pkg::ram_wr_t core_wr,
	output logic core_ack,
	output psx_loader_pkg::ram_wr_t mem_wr,
	input wire logic mem_ack,
	// Media events and user requests
	input wire psx_loader_pkg::media_evt_t media,
	input wire logic bk_load,
	input wire logic bk_save,
	input wire logic bk_autosave,
	input wire logic osd_status,
	output logic load_exe,
	output logic has_cd,
	output logic cd_hps_on,
	output logic [`PSX_CDSIZE_W-1:0] cd_size,
	output logic card1_mounted,
	output logic card2_mounted,
	output logic memcard1_load,
	output logic memcard2_load,
	output logic memcard_save,
	output logic [`PSX_HWORD_W-1:0] libcrypt_key
);

	import psx_loader_pkg::*;

	dl_beat_t beat;
	ram_wr_t loader_wr;
	logic loader_busy;
	logic loader_ack;

	dl_classify u_classify (
		.clk_1x(clk_1x),
		.rst(rst),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.beat(beat)
	);

	word_packer u_packer (
		.clk_1x(clk_1x),
		.rst(rst),
		.beat(beat),
		.loader_ack(loader_ack),
		.loader_wr(loader_wr),
		.loader_busy(loader_busy),
		.ioctl_wait(ioctl_wait)
	);

	ram_write_mux u_mux (
		.loader_busy(loader_busy),
		.loader_wr(loader_wr),
		.core_wr(core_wr),
		.mem_ack(mem_ack),
		.mem_wr(mem_wr),
		.loader_ack(loader_ack),
		.core_ack(core_ack)
	);

	media_tracker u_media (
		.clk_1x(clk_1x),
		.rst(rst),
		.beat(beat),
		.media(media),
		.bk_load(bk_load),
		.bk_save(bk_save),
		.bk_autosave(bk_autosave),
		.osd_status(osd_status),
		.load_exe(load_exe),
		.has_cd(has_cd),
		.cd_hps_on(cd_hps_on),
		.cd_size(cd_size),
		.card1_mounted(card1_mounted),
		.card2_mounted(card2_mounted),
		.memcard1_load(memcard1_load),
		.memcard2_load(memcard2_load),
		.memcard_save(memcard_save),
		.libcrypt_key(libcrypt_key)
	);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Testbench clock and reset generator
`default_nettype none

module tb_clock_gen (
	output logic clk_1x,
	output logic rst
);

	// 20 time unit period
	initial begin
		clk_1x = 1'b0;
		forever #10 clk_1x = ~clk_1x;
	end

	// Reset held for the first 3 cycles
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk_1x);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- psx_loader_tb.sv
// Testbench top with tests file reader, host and core stimulus, memory model and result checks
`default_nettype none

`include "psx_loader_params.svh"

module psx_loader_tb;

	import psx_loader_pkg::*;

	localparam int MEM_WORDS = 256;
	localparam int CYCLES_PER_REC = 50;

	logic clk_1x;
	logic rst;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic ioctl_wr;
	logic [`PSX_ADDR_W-1:0] ioctl_addr;
	logic [`PSX_HWORD_W-1:0] ioctl_dout;
	logic ioctl_wait;
	ram_wr_t core_wr;
	logic core_ack;
	ram_wr_t mem_wr;
	logic mem_ack = 1'b0;
	media_evt_t media;
	logic bk_load;
	logic bk_save;
	logic bk_autosave;
	logic osd_status;
	logic load_exe;
	logic has_cd;
	logic cd_hps_on;
	logic [`PSX_CDSIZE_W-1:0] cd_size;
	logic card1_mounted;
	logic card2_mounted;
	logic memcard1_load;
	logic memcard2_load;
	logic memcard_save;
	logic [`PSX_HWORD_W-1:0] libcrypt_key;

	// Each record holds five words in the order op a b c d
	logic [31:0] test_mem [0:MEM_WORDS-1];
	logic [7:0] word_idx;
	logic [31:0] op;
	logic [31:0] arg_a;
	logic [31:0] arg_b;
	logic [31:0] arg_c;
	logic [31:0] arg_d;
	int num_recs = 0;
	logic loaded = 1'b0;
	integer seed = 32'h43e7_f68c;
	logic [31:0] rnd;
	logic [2:0] ack_cnt = 3'd0;

	tb_clock_gen clk_gen_i (
		.clk_1x(clk_1x),
		.rst(rst)
	);

	psx_loader_top dut_i (
		.clk_1x(clk_1x),
		.rst(rst),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.ioctl_wait(ioctl_wait),
		.core_wr(core_wr),
		.core_ack(core_ack),
		.mem_wr(mem_wr),
		.mem_ack(mem_ack),
		.media(media),
		.bk_load(bk_load),
		.bk_save(bk_save),
		.bk_autosave(bk_autosave),
		.osd_status(osd_status),
		.load_exe(load_exe),
		.has_cd(has_cd),
		.cd_hps_on(cd_hps_on),
		.cd_size(cd_size),
		.card1_mounted(card1_mounted),
		.card2_mounted(card2_mounted),
		.memcard1_load(memcard1_load),
		.memcard2_load(memcard2_load),
		.memcard_save(memcard_save),
		.libcrypt_key(libcrypt_key)
	);

	// ==================================================
	// Memory model acking 1 to 4 cycles after each request
	// ==================================================

	always @(posedge clk_1x) begin
		if (rst) begin
			mem_ack <= 1'b0;
			ack_cnt <= 3'd0;
		end else begin
			mem_ack <= 1'b0;
			if (mem_wr.req) begin
				rnd = $random(seed);
				// A draw of zero acks on the very next cycle
				if (rnd[1:0] == 2'd0) begin
					mem_ack <= 1'b1;
				end else begin
					ack_cnt <= {1'b0, rnd[1:0]};
				end
			end else if (ack_cnt != 3'd0) begin
				ack_cnt <= ack_cnt - 3'd1;
				if (ack_cnt == 3'd1) begin
					mem_ack <= 1'b1;
				end
			end
		end
	end

	// ==================================================
	// Checks
	// ==================================================

	task automatic abort_run();
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped on first failure");
	endtask

	task automatic compare_wr(input string name, input ram_wr_t exp, input ram_wr_t act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_size(input string name, input logic [`PSX_CDSIZE_W-1:0] exp,
		input logic [`PSX_CDSIZE_W-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic match_key(input string name, input logic [`PSX_HWORD_W-1:0] exp,
		input logic [`PSX_HWORD_W-1:0] act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic expect_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// ==================================================
	// Operations
	// ==================================================

	task automatic start_download(input logic [7:0] index);
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index <= index;
		@(negedge clk_1x);
	endtask

	// Low then high word with the request due 2 cycles after the high write
	task automatic send_pair(input logic [`PSX_ADDR_W-1:0] lo_addr, input logic [31:0] data,
		input logic [`PSX_ADDR_W-1:0] exp_addr);
		ram_wr_t exp_wr;
		logic acked;
		exp_wr = '{req: 1'b1, addr: exp_addr, data: data, be: 4'hF};
		while (ioctl_wait) begin
			@(negedge clk_1x);
		end
		@(posedge clk_1x);
		ioctl_wr <= 1'b1;
		ioctl_addr <= lo_addr;
		ioctl_dout <= data[15:0];
		@(posedge clk_1x);
		ioctl_addr <= lo_addr | 27'd2;
		ioctl_dout <= data[31:16];
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
		@(negedge clk_1x);
		expect_flag("mem_wr.req", 1'b0, mem_wr.req);
		@(negedge clk_1x);
		compare_wr("mem_wr", exp_wr, mem_wr);
		expect_flag("ioctl_wait", 1'b1, ioctl_wait);
		acked = 1'b0;
		while (!acked) begin
			@(negedge clk_1x);
			expect_flag("mem_wr.req", 1'b0, mem_wr.req);
			expect_flag("core_ack", 1'b0, core_ack);
			expect_flag("ioctl_wait", 1'b1, ioctl_wait);
			acked = mem_ack;
		end
		@(negedge clk_1x);
		expect_flag("ioctl_wait", 1'b0, ioctl_wait);
	endtask

	// load_exe and CD results land 2 cycles after the download falls
	task automatic end_download(input logic exe_pulse, input logic check_cd,
		input logic [`PSX_CDSIZE_W-1:0] exp_size);
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		for (int step = 0; step < 4; step++) begin
			@(negedge clk_1x);
			expect_flag("load_exe", (step == 2) && exe_pulse, load_exe);
			if (step == 2 && check_cd) begin
				expect_flag("has_cd", 1'b1, has_cd);
				expect_flag("cd_hps_on", 1'b0, cd_hps_on);
				check_size("cd_size", exp_size, cd_size);
			end
		end
	endtask

	// Target 0 is the CD, 1 and 2 the memory cards
	task automatic mount_image(input logic [31:0] target, input logic [31:0] size,
		input logic flag, input logic [31:0] extra);
		@(posedge clk_1x);
		media <= '{cd_mount: (target == 32'd0), card1_mount: (target == 32'd1),
			card2_mount: (target == 32'd2), img_size: {32'd0, size}};
		@(posedge clk_1x);
		media.cd_mount <= 1'b0;
		media.card1_mount <= 1'b0;
		media.card2_mount <= 1'b0;
		@(negedge clk_1x);
		if (target == 32'd0) begin
			expect_flag("has_cd", flag, has_cd);
			if (flag) begin
				expect_flag("cd_hps_on", 1'b1, cd_hps_on);
				check_size("cd_size", extra[`PSX_CDSIZE_W-1:0], cd_size);
			end
		end else if (target == 32'd1) begin
			expect_flag("card1_mounted", flag, card1_mounted);
		end else begin
			expect_flag("card2_mounted", flag, card2_mounted);
		end
		expect_flag("memcard1_load", (target == 32'd1) && extra[0], memcard1_load);
		expect_flag("memcard2_load", (target == 32'd2) && extra[0], memcard2_load);
		@(negedge clk_1x);
		expect_flag("memcard1_load", 1'b0, memcard1_load);
		expect_flag("memcard2_load", 1'b0, memcard2_load);
	endtask

	// Target 0 is load, 1 save and 2 autosave
	// Pulses land 2 cycles after the rise
	task automatic raise_request(input logic [31:0] target, input logic card1_exp,
		input logic card2_exp, input logic save_exp);
		@(posedge clk_1x);
		if (target == 32'd0) begin
			bk_load <= 1'b1;
		end else if (target == 32'd1) begin
			bk_save <= 1'b1;
		end else begin
			bk_autosave <= 1'b1;
			osd_status <= 1'b1;
		end
		for (int step = 0; step < 5; step++) begin
			@(negedge clk_1x);
			expect_flag("memcard1_load", (step == 2) && card1_exp, memcard1_load);
			expect_flag("memcard2_load", (step == 2) && card2_exp, memcard2_load);
			expect_flag("memcard_save", (step == 2) && save_exp, memcard_save);
		end
		@(posedge clk_1x);
		bk_load <= 1'b0;
		bk_save <= 1'b0;
		bk_autosave <= 1'b0;
		osd_status <= 1'b0;
		// Falling edges pulse nothing
		for (int step = 0; step < 3; step++) begin
			@(negedge clk_1x);
			expect_flag("memcard1_load", 1'b0, memcard1_load);
			expect_flag("memcard2_load", 1'b0, memcard2_load);
			expect_flag("memcard_save", 1'b0, memcard_save);
		end
	endtask

	task automatic core_write(input logic [`PSX_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		ram_wr_t exp_wr;
		logic acked;
		exp_wr = '{req: 1'b1, addr: addr, data: data, be: be};
		@(posedge clk_1x);
		core_wr <= exp_wr;
		@(negedge clk_1x);
		compare_wr("mem_wr", exp_wr, mem_wr);
		@(posedge clk_1x);
		core_wr.req <= 1'b0;
		acked = 1'b0;
		while (!acked) begin
			@(negedge clk_1x);
			expect_flag("core_ack", mem_ack, core_ack);
			acked = mem_ack;
		end
	endtask

	// Single beat of a protection key download
	task automatic send_key(input logic [`PSX_ADDR_W-1:0] addr,
		input logic [`PSX_HWORD_W-1:0] data, input logic [`PSX_HWORD_W-1:0] exp_key);
		@(posedge clk_1x);
		ioctl_wr <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
		@(posedge clk_1x);
		@(negedge clk_1x);
		match_key("libcrypt_key", exp_key, libcrypt_key);
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		core_wr = '0;
		media = '0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		bk_autosave = 1'b0;
		osd_status = 1'b0;
		$readmemh("psx_loader_tests.txt", test_mem);
		// Records run up to the first op of zero
		word_idx = 8'd0;
		while (word_idx < 8'd250 && test_mem[word_idx] != 32'd0) begin
			num_recs = num_recs + 1;
			word_idx = word_idx + 8'd5;
		end
		loaded = 1'b1;
		if (num_recs == 0) begin
			$display("No records found in psx_loader_tests.txt");
			abort_run();
		end
		@(negedge clk_1x);
		while (rst) begin
			@(negedge clk_1x);
		end
		expect_flag("ioctl_wait", 1'b0, ioctl_wait);
		expect_flag("mem_wr.req", 1'b0, mem_wr.req);
		expect_flag("load_exe", 1'b0, load_exe);
		expect_flag("memcard1_load", 1'b0, memcard1_load);
		expect_flag("memcard2_load", 1'b0, memcard2_load);
		expect_flag("memcard_save", 1'b0, memcard_save);
		expect_flag("has_cd", 1'b0, has_cd);
		expect_flag("card1_mounted", 1'b0, card1_mounted);
		expect_flag("card2_mounted", 1'b0, card2_mounted);
		word_idx = 8'd0;
		for (int i = 0; i < num_recs; i++) begin
			op = test_mem[word_idx];
			arg_a = test_mem[word_idx + 8'd1];
			arg_b = test_mem[word_idx + 8'd2];
			arg_c = test_mem[word_idx + 8'd3];
			arg_d = test_mem[word_idx + 8'd4];
			case (op)
				32'd1: start_download(arg_a[7:0]);
				32'd2: send_pair(arg_a[`PSX_ADDR_W-1:0], arg_b, arg_c[`PSX_ADDR_W-1:0]);
				32'd3: end_download(arg_a[0], arg_b[0], arg_c[`PSX_CDSIZE_W-1:0]);
				32'd4: mount_image(arg_a, arg_b, arg_c[0], arg_d);
				32'd5: raise_request(arg_a, arg_b[0], arg_c[0], arg_d[0]);
				32'd6: core_write(arg_a[`PSX_ADDR_W-1:0], arg_b, arg_c[3:0]);
				32'd7: send_key(arg_a[`PSX_ADDR_W-1:0], arg_b[15:0], arg_c[15:0]);
				default: begin
					$display("Unknown operation %0h in record %0d of the tests file", op, i);
					abort_run();
				end
			endcase
			word_idx = word_idx + 8'd5;
		end
		$display("TESTBENCH PASSED");
		$finish;
	end

	// Watchdog sized from the number of records
	initial begin
		wait (loaded);
		repeat (num_recs * CYCLES_PER_REC + 10) @(posedge clk_1x);
		$display("Timeout: the %0d test records did not finish in time", num_recs);
		abort_run();
	end

endmodule

`default_nettype wire

//--- psx_loader_tests.txt
// op a b c d (hex). 1 start a=index, 2 pair a=lo addr b=data c=mem addr, 3 end a=load_exe b=cd c=size
// 4 mount a=0 cd/1,2 card b=size c=flag d=load or cd_size, 5 request a=0 load/1 save/2 auto, 6 core, 7 key
00000001 00000000 00000000 00000000 00000000
00000002 00000000 BEEF1234 00200000 00000000
00000002 00000004 CAFE5678 00200004 00000000
00000002 00000100 01020304 00200100 00000000
00000003 00000000 00000000 00000000 00000000
00000006 00001000 DEADBEEF 0000000F 00000000
00000001 00000001 00000000 00000000 00000000
00000002 00000000 11112222 00400000 00000000
00000002 00000008 33334444 00400008 00000000
00000003 00000001 00000000 00000000 00000000
00000001 00000042 00000000 00000000 00000000
00000002 00000000 AAAA5555 00000000 00000000
00000002 00000004 12345678 00000004 00000000
00000003 00000000 00000001 00000006 00000000
00000004 00000000 00012000 00000001 00012000
00000004 00000000 00000000 00000000 00000000
00000004 00000001 00020000 00000001 00000001
00000004 00000002 00020000 00000001 00000001
00000004 00000001 00000000 00000000 00000000
00000005 00000000 00000001 00000001 00000000
00000005 00000001 00000000 00000000 00000001
00000005 00000002 00000000 00000000 00000001
00000001 000000FA 00000000 00000000 00000000
00000007 00000000 00005A3C 00005A3C 00000000
00000003 00000000 00000000 00000000 00000000
00000006 00002000 0BADF00D 00000003 00000000
00000000 00000000 00000000 00000000 00000000

//--- psx_loader.f
+incdir+.
psx_loader_pkg.sv
dl_classify.sv
word_packer.sv
ram_write_mux.sv
media_tracker.sv
psx_loader_top.sv
tb_clock_gen.sv
psx_loader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module psx_loader_tb -f psx_loader.f
./obj_dir/Vpsx_loader_tb
